// File: filelist.f
source/scr1_mem_pkg.sv
source/scr1_dmem_router.sv
source/scr1_tcm.sv
source/scr1_timer.sv
source/scr1_dmem_resp_mux.sv
source/scr1_top_mem.sv
verif/scr1_top_mem_sva.sv
verif/tb_scr1_top_mem.sv

// File: source/scr1_dmem_resp_mux.sv
/*
 * Remembers where the accepted request went and builds the core response.
 * Response comes exactly one cycle after acceptance; IDLE otherwise.
 */
`default_nettype none

module scr1_dmem_resp_mux (
    input  logic                                        clk,
    input  logic                                        core_rst_n_local,

    // Strobes from the router
    input  logic                                        tcm_req_i,
    input  logic                                        timer_req_i,
    input  logic                                        err_req_i,
    input  scr1_mem_pkg::scr1_mem_cmd_e                 cmd_i,

    // Target returns
    input  logic [scr1_mem_pkg::SCR1_DMEM_DWIDTH-1:0]   tcm_rdata_i,
    input  logic [scr1_mem_pkg::SCR1_DMEM_DWIDTH-1:0]   timer_rdata_i,
    input  logic                                        timer_err_i,

    // Response to the core side
    output scr1_mem_pkg::scr1_mem_resp_e                dmem_resp_o,
    output logic [scr1_mem_pkg::SCR1_DMEM_DWIDTH-1:0]   dmem_rdata_o
);

logic tcm_q;
logic timer_q;
logic err_q;
logic rd_q;

// Destination of the request accepted last cycle
always_ff @(posedge clk) begin
    if (~core_rst_n_local) begin
        tcm_q   <= 1'b0;
        timer_q <= 1'b0;
        err_q   <= 1'b0;
        rd_q    <= 1'b0;
    end else begin
        tcm_q   <= tcm_req_i;
        timer_q <= timer_req_i;
        err_q   <= err_req_i;
        rd_q    <= (cmd_i == scr1_mem_pkg::SCR1_MEM_CMD_RD);
    end
end

always_comb begin
    dmem_resp_o  = scr1_mem_pkg::SCR1_MEM_RESP_IDLE;
    dmem_rdata_o = '0;
    if (err_q || (timer_q && timer_err_i)) begin
        dmem_resp_o = scr1_mem_pkg::SCR1_MEM_RESP_RDY_ER;   // Data stays zero
    end else if (tcm_q) begin
        dmem_resp_o = scr1_mem_pkg::SCR1_MEM_RESP_RDY_OK;
        if (rd_q) dmem_rdata_o = tcm_rdata_i;
    end else if (timer_q) begin
        dmem_resp_o = scr1_mem_pkg::SCR1_MEM_RESP_RDY_OK;
        if (rd_q) dmem_rdata_o = timer_rdata_i;
    end
end

endmodule : scr1_dmem_resp_mux

`default_nettype wire

// File: source/scr1_dmem_router.sv
/*
 * Purely combinational decode of the data-memory request strobe.
 * TCM window wins if the two windows ever overlap.
 * Misaligned accesses never reach a target, so they cannot alter state.
 */
`default_nettype none

module scr1_dmem_router #(
    parameter logic [scr1_mem_pkg::SCR1_DMEM_AWIDTH-1:0] TCM_ADDR_MASK =
        scr1_mem_pkg::SCR1_TCM_ADDR_MASK,
    parameter logic [scr1_mem_pkg::SCR1_DMEM_AWIDTH-1:0] TCM_ADDR_PATTERN =
        scr1_mem_pkg::SCR1_TCM_ADDR_PATTERN,
    parameter logic [scr1_mem_pkg::SCR1_DMEM_AWIDTH-1:0] TIMER_ADDR_MASK =
        scr1_mem_pkg::SCR1_TIMER_ADDR_MASK,
    parameter logic [scr1_mem_pkg::SCR1_DMEM_AWIDTH-1:0] TIMER_ADDR_PATTERN =
        scr1_mem_pkg::SCR1_TIMER_ADDR_PATTERN
) (
    // Request from the core side
    input  logic                                          dmem_req_i,
    input  logic [scr1_mem_pkg::SCR1_DMEM_AWIDTH-1:0]     dmem_addr_i,
    input  scr1_mem_pkg::scr1_mem_width_e                 dmem_width_i,

    // One-hot destination strobes
    output logic                                          tcm_req_o,
    output logic                                          timer_req_o,
    output logic                                          err_req_o
);

logic tcm_hit;
logic timer_hit;
logic misaligned;

//----------------------------------------
// Address decode
//----------------------------------------
assign tcm_hit   = ((dmem_addr_i & TCM_ADDR_MASK) == TCM_ADDR_PATTERN);
assign timer_hit = ((dmem_addr_i & TIMER_ADDR_MASK) == TIMER_ADDR_PATTERN);

// Alignment against access size
always_comb begin
    case (dmem_width_i)
        scr1_mem_pkg::SCR1_MEM_WIDTH_BYTE:  misaligned = 1'b0;
        scr1_mem_pkg::SCR1_MEM_WIDTH_HWORD: misaligned = dmem_addr_i[0];
        scr1_mem_pkg::SCR1_MEM_WIDTH_WORD:  misaligned = |dmem_addr_i[1:0];
        default:                            misaligned = 1'b1;  // Unknown size
    endcase
end

//----------------------------------------
// Strobe steering
//----------------------------------------
assign tcm_req_o   = dmem_req_i & ~misaligned & tcm_hit;
assign timer_req_o = dmem_req_i & ~misaligned & ~tcm_hit & timer_hit;

// Everything else is answered with an error
assign err_req_o   = dmem_req_i & (misaligned | ~(tcm_hit | timer_hit));

endmodule : scr1_dmem_router

`default_nettype wire

// File: source/scr1_mem_pkg.sv
/*
 * Shared widths, encodings and default address map of the data-memory subsystem.
 * Windows are given as mask/pattern pairs and must not overlap.
 */
`default_nettype none

package scr1_mem_pkg;

    //----------------------------------------
    // Bus widths
    //----------------------------------------
    localparam int unsigned SCR1_DMEM_AWIDTH = 32;
    localparam int unsigned SCR1_DMEM_DWIDTH = 32;

    //----------------------------------------
    // Request and response encodings
    //----------------------------------------
    typedef enum logic {
        SCR1_MEM_CMD_RD = 1'b0,
        SCR1_MEM_CMD_WR = 1'b1
    } scr1_mem_cmd_e;

    typedef enum logic [1:0] {
        SCR1_MEM_WIDTH_BYTE  = 2'b00,
        SCR1_MEM_WIDTH_HWORD = 2'b01,
        SCR1_MEM_WIDTH_WORD  = 2'b10
    } scr1_mem_width_e;

    typedef enum logic [1:0] {
        SCR1_MEM_RESP_IDLE   = 2'b00,   // No response this cycle
        SCR1_MEM_RESP_RDY_OK = 2'b01,
        SCR1_MEM_RESP_RDY_ER = 2'b10
    } scr1_mem_resp_e;

    //----------------------------------------
    // Default address map
    //----------------------------------------
    localparam logic [31:0] SCR1_TCM_ADDR_MASK      = 32'hFFFF_0000;    // 64 KB
    localparam logic [31:0] SCR1_TCM_ADDR_PATTERN   = 32'h0048_0000;
    localparam logic [31:0] SCR1_TIMER_ADDR_MASK    = 32'hFFFF_FFE0;    // 32 bytes
    localparam logic [31:0] SCR1_TIMER_ADDR_PATTERN = 32'h0049_0000;

    // Timer register offsets inside its window
    localparam logic [4:0] SCR1_TIMER_CTRL       = 5'h00;  // Bit 0 is enable
    localparam logic [4:0] SCR1_TIMER_MTIMELO    = 5'h08;
    localparam logic [4:0] SCR1_TIMER_MTIMEHI    = 5'h0C;
    localparam logic [4:0] SCR1_TIMER_MTIMECMPLO = 5'h10;
    localparam logic [4:0] SCR1_TIMER_MTIMECMPHI = 5'h14;

endpackage : scr1_mem_pkg

`default_nettype wire

// File: source/scr1_tcm.sv
/*
 * Single-port data TCM, one word per entry, TCM_SIZE a power of two in bytes.
 * Write data comes in the low lanes and is shifted to the addressed lanes.
 * Reads return the whole word one cycle later; lane selection is left to the core.
 */
`default_nettype none

module scr1_tcm #(
    parameter int unsigned TCM_SIZE = 65536
) (
    input  logic                                        clk,
    input  logic                                        core_rst_n_local,

    // Request from the router
    input  logic                                        req_i,
    input  scr1_mem_pkg::scr1_mem_cmd_e                 cmd_i,
    input  scr1_mem_pkg::scr1_mem_width_e               width_i,
    input  logic [$clog2(TCM_SIZE)-1:0]                 addr_i,
    input  logic [scr1_mem_pkg::SCR1_DMEM_DWIDTH-1:0]   wdata_i,

    // Read data, valid the cycle after a read
    output logic [scr1_mem_pkg::SCR1_DMEM_DWIDTH-1:0]   rdata_o
);

localparam int unsigned DW    = scr1_mem_pkg::SCR1_DMEM_DWIDTH;
localparam int unsigned NB    = DW / 8;             // Byte lanes per word
localparam int unsigned DEPTH = TCM_SIZE / NB;
localparam int unsigned AW    = $clog2(TCM_SIZE);

logic [DW-1:0]   mem [0:DEPTH-1];
logic [AW-3:0]   word_idx;
logic [NB-1:0]   byte_en;
logic [DW-1:0]   wdata_lane;
logic            wr_en;
logic            rd_en;

assign word_idx = addr_i[AW-1:2];
assign wr_en    = req_i & (cmd_i == scr1_mem_pkg::SCR1_MEM_CMD_WR);
assign rd_en    = req_i & (cmd_i == scr1_mem_pkg::SCR1_MEM_CMD_RD);

//----------------------------------------
// Byte enables and lane placement
//----------------------------------------
always_comb begin
    case (width_i)
        scr1_mem_pkg::SCR1_MEM_WIDTH_BYTE:  byte_en = 4'b0001 << addr_i[1:0];
        scr1_mem_pkg::SCR1_MEM_WIDTH_HWORD: byte_en = 4'b0011 << addr_i[1:0];
        default:                            byte_en = 4'b1111;
    endcase
end

assign wdata_lane = wdata_i << (8 * addr_i[1:0]);

//----------------------------------------
// Storage
//----------------------------------------
always_ff @(posedge clk) begin
    if (wr_en) begin
        for (int i = 0; i < NB; i++) begin
            if (byte_en[i]) begin
                mem[word_idx][8*i +: 8] <= wdata_lane[8*i +: 8];
            end
        end
    end
end

// Registered read port
always_ff @(posedge clk) begin
    if (~core_rst_n_local) begin
        rdata_o <= '0;
    end else if (rd_en) begin
        rdata_o <= mem[word_idx];   // Full word regardless of size
    end
end

endmodule : scr1_tcm

`default_nettype wire

// File: source/scr1_timer.sv
/*
 * Memory-mapped machine timer counting clk cycles while enabled.
 * Only word accesses to the listed offsets are legal; others flag an error.
 * A write to either mtime half wins over the increment in that cycle.
 */
`default_nettype none

module scr1_timer (
    input  logic                                        clk,
    input  logic                                        core_rst_n_local,

    // Register access from the router
    input  logic                                        req_i,
    input  scr1_mem_pkg::scr1_mem_cmd_e                 cmd_i,
    input  scr1_mem_pkg::scr1_mem_width_e               width_i,
    input  logic [4:0]                                  addr_i,
    input  logic [scr1_mem_pkg::SCR1_DMEM_DWIDTH-1:0]   wdata_i,

    // Response, one cycle after the request
    output logic [scr1_mem_pkg::SCR1_DMEM_DWIDTH-1:0]   rdata_o,
    output logic                                        err_o,

    output logic                                        timer_irq_o
);

localparam int unsigned DW = scr1_mem_pkg::SCR1_DMEM_DWIDTH;

logic           ctrl_en;
logic [63:0]    mtime;
logic [63:0]    mtimecmp;

logic           offs_ok;
logic           acc_ok;
logic           wr_en;
logic           rd_en;
logic [DW-1:0]  rd_val;

//----------------------------------------
// Access decode
//----------------------------------------
always_comb begin
    offs_ok = 1'b1;
    rd_val  = '0;
    case (addr_i)
        scr1_mem_pkg::SCR1_TIMER_CTRL:       rd_val = {{(DW-1){1'b0}}, ctrl_en};
        scr1_mem_pkg::SCR1_TIMER_MTIMELO:    rd_val = mtime[31:0];
        scr1_mem_pkg::SCR1_TIMER_MTIMEHI:    rd_val = mtime[63:32];
        scr1_mem_pkg::SCR1_TIMER_MTIMECMPLO: rd_val = mtimecmp[31:0];
        scr1_mem_pkg::SCR1_TIMER_MTIMECMPHI: rd_val = mtimecmp[63:32];
        default:                             offs_ok = 1'b0;
    endcase
end

assign acc_ok = offs_ok & (width_i == scr1_mem_pkg::SCR1_MEM_WIDTH_WORD);
assign wr_en  = req_i & acc_ok & (cmd_i == scr1_mem_pkg::SCR1_MEM_CMD_WR);
assign rd_en  = req_i & acc_ok & (cmd_i == scr1_mem_pkg::SCR1_MEM_CMD_RD);

//----------------------------------------
// Registers
//----------------------------------------
always_ff @(posedge clk) begin
    if (~core_rst_n_local) begin
        ctrl_en <= 1'b0;
    end else if (wr_en && (addr_i == scr1_mem_pkg::SCR1_TIMER_CTRL)) begin
        ctrl_en <= wdata_i[0];
    end
end

always_ff @(posedge clk) begin
    if (~core_rst_n_local) begin
        mtime <= '0;
    end else if (wr_en && (addr_i == scr1_mem_pkg::SCR1_TIMER_MTIMELO)) begin
        mtime[31:0] <= wdata_i;
    end else if (wr_en && (addr_i == scr1_mem_pkg::SCR1_TIMER_MTIMEHI)) begin
        mtime[63:32] <= wdata_i;
    end else if (ctrl_en) begin
        mtime <= mtime + 64'd1;     // One tick per clk
    end
end

always_ff @(posedge clk) begin
    if (~core_rst_n_local) begin
        mtimecmp <= '1;             // Far future, no IRQ
    end else if (wr_en && (addr_i == scr1_mem_pkg::SCR1_TIMER_MTIMECMPLO)) begin
        mtimecmp[31:0] <= wdata_i;
    end else if (wr_en && (addr_i == scr1_mem_pkg::SCR1_TIMER_MTIMECMPHI)) begin
        mtimecmp[63:32] <= wdata_i;
    end
end

// Compare every cycle
always_ff @(posedge clk) begin
    if (~core_rst_n_local) begin
        timer_irq_o <= 1'b0;
    end else begin
        timer_irq_o <= (mtime >= mtimecmp);
    end
end

//----------------------------------------
// Response
//----------------------------------------
always_ff @(posedge clk) begin
    if (~core_rst_n_local) begin
        err_o <= 1'b0;
    end else begin
        err_o <= req_i & ~acc_ok;
    end
end

always_ff @(posedge clk) begin
    if (req_i) begin
        rdata_o <= rd_en ? rd_val : '0;     // Value before this edge
    end
end

endmodule : scr1_timer

`default_nettype wire

// File: source/scr1_top_mem.sv
/*
 * Data-memory subsystem: router, TCM, machine timer and response mux.
 * Every request is accepted at once and answered one cycle later, no back-pressure.
 * TCM mask must describe a power-of-two window; its size is derived from it.
 */
`default_nettype none

module scr1_top_mem #(
    parameter logic [scr1_mem_pkg::SCR1_DMEM_AWIDTH-1:0] TCM_ADDR_MASK =
        scr1_mem_pkg::SCR1_TCM_ADDR_MASK,
    parameter logic [scr1_mem_pkg::SCR1_DMEM_AWIDTH-1:0] TCM_ADDR_PATTERN =
        scr1_mem_pkg::SCR1_TCM_ADDR_PATTERN,
    parameter logic [scr1_mem_pkg::SCR1_DMEM_AWIDTH-1:0] TIMER_ADDR_MASK =
        scr1_mem_pkg::SCR1_TIMER_ADDR_MASK,
    parameter logic [scr1_mem_pkg::SCR1_DMEM_AWIDTH-1:0] TIMER_ADDR_PATTERN =
        scr1_mem_pkg::SCR1_TIMER_ADDR_PATTERN
) (
    input  logic                                        clk,
    input  logic                                        core_rst_n_local,

    // Data memory request
    input  logic                                        dmem_req_i,
    input  scr1_mem_pkg::scr1_mem_cmd_e                 dmem_cmd_i,
    input  scr1_mem_pkg::scr1_mem_width_e               dmem_width_i,
    input  logic [scr1_mem_pkg::SCR1_DMEM_AWIDTH-1:0]   dmem_addr_i,
    input  logic [scr1_mem_pkg::SCR1_DMEM_DWIDTH-1:0]   dmem_wdata_i,

    // Data memory response
    output scr1_mem_pkg::scr1_mem_resp_e                dmem_resp_o,
    output logic [scr1_mem_pkg::SCR1_DMEM_DWIDTH-1:0]   dmem_rdata_o,

    output logic                                        timer_irq_o
);

// TCM size in bytes from the window mask
localparam int unsigned TCM_SIZE = 32'(~TCM_ADDR_MASK + 1'b1);
localparam int unsigned TCM_AW   = $clog2(TCM_SIZE);

logic                                       tcm_req;
logic                                       timer_req;
logic                                       err_req;
logic [scr1_mem_pkg::SCR1_DMEM_DWIDTH-1:0]  tcm_rdata;
logic [scr1_mem_pkg::SCR1_DMEM_DWIDTH-1:0]  timer_rdata;
logic                                       timer_err;

//----------------------------------------
// Request decode
//----------------------------------------
scr1_dmem_router #(
    .TCM_ADDR_MASK      (TCM_ADDR_MASK     ),
    .TCM_ADDR_PATTERN   (TCM_ADDR_PATTERN  ),
    .TIMER_ADDR_MASK    (TIMER_ADDR_MASK   ),
    .TIMER_ADDR_PATTERN (TIMER_ADDR_PATTERN)
) i_dmem_router (
    .dmem_req_i     (dmem_req_i  ),
    .dmem_addr_i    (dmem_addr_i ),
    .dmem_width_i   (dmem_width_i),
    .tcm_req_o      (tcm_req     ),
    .timer_req_o    (timer_req   ),
    .err_req_o      (err_req     )
);

//----------------------------------------
// Targets
//----------------------------------------
scr1_tcm #(
    .TCM_SIZE   (TCM_SIZE)
) i_tcm (
    .clk                (clk                      ),
    .core_rst_n_local   (core_rst_n_local         ),
    .req_i              (tcm_req                  ),
    .cmd_i              (dmem_cmd_i               ),
    .width_i            (dmem_width_i             ),
    .addr_i             (dmem_addr_i[TCM_AW-1:0]  ),  // Offset within window
    .wdata_i            (dmem_wdata_i             ),
    .rdata_o            (tcm_rdata                )
);

scr1_timer i_timer (
    .clk                (clk              ),
    .core_rst_n_local   (core_rst_n_local ),
    .req_i              (timer_req        ),
    .cmd_i              (dmem_cmd_i       ),
    .width_i            (dmem_width_i     ),
    .addr_i             (dmem_addr_i[4:0] ),
    .wdata_i            (dmem_wdata_i     ),
    .rdata_o            (timer_rdata      ),
    .err_o              (timer_err        ),
    .timer_irq_o        (timer_irq_o      )
);

//----------------------------------------
// Response
//----------------------------------------
scr1_dmem_resp_mux i_dmem_resp_mux (
    .clk                (clk              ),
    .core_rst_n_local   (core_rst_n_local ),
    .tcm_req_i          (tcm_req          ),
    .timer_req_i        (timer_req        ),
    .err_req_i          (err_req          ),
    .cmd_i              (dmem_cmd_i       ),
    .tcm_rdata_i        (tcm_rdata        ),
    .timer_rdata_i      (timer_rdata      ),
    .timer_err_i        (timer_err        ),
    .dmem_resp_o        (dmem_resp_o      ),
    .dmem_rdata_o       (dmem_rdata_o     )
);

endmodule : scr1_top_mem

`default_nettype wire

// File: verif/scr1_top_mem_sva.sv
/*
 * Response protocol checks, bound into every scr1_top_mem instance.
 * Protocol checks are disabled while core_rst_n_local is low.
 */
`default_nettype none

module scr1_top_mem_sva (
    input logic         clk,
    input logic         core_rst_n_local,
    input logic         dmem_req_i,
    input logic [1:0]   dmem_resp_i,
    input logic         timer_irq_i
);

int unsigned assert_fails = 0;

// Response exactly one cycle after acceptance
resp_after_req: assert property (
    @(posedge clk) disable iff (!core_rst_n_local)
    dmem_req_i |=> (dmem_resp_i != scr1_mem_pkg::SCR1_MEM_RESP_IDLE)
) else begin
    assert_fails++;
    $error("No response in the cycle after a request");
end

idle_without_req: assert property (
    @(posedge clk) disable iff (!core_rst_n_local)
    !dmem_req_i |=> (dmem_resp_i == scr1_mem_pkg::SCR1_MEM_RESP_IDLE)
) else begin
    assert_fails++;
    $error("Response seen without a request in the previous cycle");
end

irq_low_in_reset: assert property (
    @(posedge clk) !core_rst_n_local |=> !timer_irq_i
) else begin
    assert_fails++;
    $error("timer_irq_o high during reset");
end

endmodule : scr1_top_mem_sva

bind scr1_top_mem scr1_top_mem_sva sva_i (
    .clk                (clk             ),
    .core_rst_n_local   (core_rst_n_local),
    .dmem_req_i         (dmem_req_i      ),
    .dmem_resp_i        (dmem_resp_o     ),
    .timer_irq_i        (timer_irq_o     )
);

`default_nettype wire

// File: verif/tb_scr1_top_mem.sv
/*
 * Table-driven testbench for the data-memory subsystem with default address map.
 * Requests go back to back at one per cycle; each response is checked one cycle later.
 * TCM words are only read after the table has written them.
 */
`default_nettype none

module tb_scr1_top_mem;

localparam int MAX_ENTRIES = 40;
localparam logic [31:0] TCM_BASE = scr1_mem_pkg::SCR1_TCM_ADDR_PATTERN;
localparam logic [31:0] TMR_BASE = scr1_mem_pkg::SCR1_TIMER_ADDR_PATTERN;
localparam logic [31:0] K_ADDR   = TCM_BASE + 32'h200;     // Word for lane tests

localparam scr1_mem_pkg::scr1_mem_cmd_e   RD     = scr1_mem_pkg::SCR1_MEM_CMD_RD;
localparam scr1_mem_pkg::scr1_mem_cmd_e   WR     = scr1_mem_pkg::SCR1_MEM_CMD_WR;
localparam scr1_mem_pkg::scr1_mem_width_e W_BYTE = scr1_mem_pkg::SCR1_MEM_WIDTH_BYTE;
localparam scr1_mem_pkg::scr1_mem_width_e W_HALF = scr1_mem_pkg::SCR1_MEM_WIDTH_HWORD;
localparam scr1_mem_pkg::scr1_mem_width_e W_WORD = scr1_mem_pkg::SCR1_MEM_WIDTH_WORD;
localparam scr1_mem_pkg::scr1_mem_resp_e  IDLE   = scr1_mem_pkg::SCR1_MEM_RESP_IDLE;
localparam scr1_mem_pkg::scr1_mem_resp_e  OK     = scr1_mem_pkg::SCR1_MEM_RESP_RDY_OK;
localparam scr1_mem_pkg::scr1_mem_resp_e  ER     = scr1_mem_pkg::SCR1_MEM_RESP_RDY_ER;

logic                           clk;
logic                           core_rst_n_local;
logic                           dmem_req;
scr1_mem_pkg::scr1_mem_cmd_e    dmem_cmd;
scr1_mem_pkg::scr1_mem_width_e  dmem_width;
logic [31:0]                    dmem_addr;
logic [31:0]                    dmem_wdata;
scr1_mem_pkg::scr1_mem_resp_e   dmem_resp;
logic [31:0]                    dmem_rdata;
logic                           timer_irq;

// Stimulus table
string                          t_name  [0:MAX_ENTRIES-1];
scr1_mem_pkg::scr1_mem_cmd_e    t_cmd   [0:MAX_ENTRIES-1];
scr1_mem_pkg::scr1_mem_width_e  t_width [0:MAX_ENTRIES-1];
logic [31:0]                    t_addr  [0:MAX_ENTRIES-1];
logic [31:0]                    t_wdata [0:MAX_ENTRIES-1];
scr1_mem_pkg::scr1_mem_resp_e   t_resp  [0:MAX_ENTRIES-1];
logic [31:0]                    t_rdata [0:MAX_ENTRIES-1];
logic                           t_dc    [0:MAX_ENTRIES-1];    // Ignore read data
logic [31:0]                    t_got   [0:MAX_ENTRIES-1];

int n_entries = 0;
int n_total   = 0;      // Entries queued over the whole run
int n_run     = 0;
int n_fail    = 0;
int cycle_cnt = 0;
int seed      = 64143;

logic [31:0] rnd_word [0:3];
logic [31:0] merged;

scr1_top_mem dut_i (
    .clk                (clk             ),
    .core_rst_n_local   (core_rst_n_local),
    .dmem_req_i         (dmem_req        ),
    .dmem_cmd_i         (dmem_cmd        ),
    .dmem_width_i       (dmem_width      ),
    .dmem_addr_i        (dmem_addr       ),
    .dmem_wdata_i       (dmem_wdata      ),
    .dmem_resp_o        (dmem_resp       ),
    .dmem_rdata_o       (dmem_rdata      ),
    .timer_irq_o        (timer_irq       )
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

//----------------------------------------
// Helpers
//----------------------------------------
// Expected word after a sized write to the lanes given by size and offset
function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                            input logic [31:0] wdata,
                                            input scr1_mem_pkg::scr1_mem_width_e width,
                                            input logic [1:0] offs);
    logic [31:0] lane_mask;
    case (width)
        W_BYTE:  lane_mask = 32'h0000_00FF;
        W_HALF:  lane_mask = 32'h0000_FFFF;
        default: lane_mask = 32'hFFFF_FFFF;
    endcase
    lane_mask = lane_mask << (8 * offs);
    return (old_word & ~lane_mask) | ((wdata << (8 * offs)) & lane_mask);
endfunction

function automatic logic [31:0] timer_addr(input logic [4:0] offs);
    return TMR_BASE | {27'd0, offs};
endfunction

task automatic add_entry(input string name, input scr1_mem_pkg::scr1_mem_cmd_e cmd,
                         input scr1_mem_pkg::scr1_mem_width_e width, input logic [31:0] addr,
                         input logic [31:0] wdata, input scr1_mem_pkg::scr1_mem_resp_e resp,
                         input logic [31:0] rdata, input logic dc);
    t_name[n_entries]  = name;
    t_cmd[n_entries]   = cmd;
    t_width[n_entries] = width;
    t_addr[n_entries]  = addr;
    t_wdata[n_entries] = wdata;
    t_resp[n_entries]  = resp;
    t_rdata[n_entries] = rdata;
    t_dc[n_entries]    = dc;
    n_entries++;
    n_total++;
endtask

// Writes never return data
task automatic add_write(input string name, input scr1_mem_pkg::scr1_mem_width_e width,
                         input logic [31:0] addr, input logic [31:0] wdata,
                         input scr1_mem_pkg::scr1_mem_resp_e resp);
    add_entry(name, WR, width, addr, wdata, resp, 32'd0, 1'b0);
endtask

task automatic check_entry(input int idx);
    t_got[idx] = dmem_rdata;
    n_run++;
    if (dmem_resp !== t_resp[idx]) begin
        $display("ERROR %s: resp expected %0d actual %0d", t_name[idx], t_resp[idx], dmem_resp);
        n_fail++;
    end else if (!t_dc[idx] && (dmem_rdata !== t_rdata[idx])) begin
        $display("ERROR %s: rdata expected %h actual %h", t_name[idx], t_rdata[idx], dmem_rdata);
        n_fail++;
    end else begin
        $display("ok    %s", t_name[idx]);
    end
endtask

// One request per cycle with entry k-1 checked while entry k is decoded
task automatic run_table();
    int k;
    for (k = 0; k <= n_entries; k++) begin
        @(posedge clk);
        if (k < n_entries) begin
            dmem_req   <= 1'b1;
            dmem_cmd   <= t_cmd[k];
            dmem_width <= t_width[k];
            dmem_addr  <= t_addr[k];
            dmem_wdata <= t_wdata[k];
        end else begin
            dmem_req   <= 1'b0;
        end
        @(negedge clk);
        if (k > 0) check_entry(k - 1);
    end
endtask

task automatic wait_irq(input string name, input logic level, input int max_cycles);
    int c;
    c = 0;
    while ((timer_irq !== level) && (c < max_cycles)) begin
        @(negedge clk);
        c++;
    end
    n_run++;
    if (timer_irq !== level) begin
        $display("%s: timer_irq_o did not go to %0d within %0d cycles", name, level, max_cycles);
        n_fail++;
    end else begin
        $display("ok    %s after %0d cycles", name, c);
    end
endtask

//----------------------------------------
// Watchdog
//----------------------------------------
initial begin
    while (cycle_cnt <= 16 + n_total + 200) begin
        @(posedge clk);
        cycle_cnt++;
    end
    $display("Timeout: run still going after %0d cycles", cycle_cnt);
    $display("Some tests failed");
    $finish;
end

//----------------------------------------
// Main sequence
//----------------------------------------
initial begin
    core_rst_n_local = 1'b0;
    dmem_req         = 1'b0;
    dmem_cmd         = RD;
    dmem_width       = W_WORD;
    dmem_addr        = 32'd0;
    dmem_wdata       = 32'd0;
    repeat (16) @(posedge clk);
    core_rst_n_local <= 1'b1;
    @(negedge clk);
    n_run++;
    if (dmem_resp !== IDLE) begin
        $display("ERROR reset_state: resp expected %0d actual %0d", IDLE, dmem_resp);
        n_fail++;
    end else if (timer_irq !== 1'b0) begin
        $display("ERROR reset_state: timer_irq_o expected 0 actual %b", timer_irq);
        n_fail++;
    end else begin
        $display("ok    reset_state");
    end

    for (int j = 0; j < 4; j++) rnd_word[j] = $random(seed);

    // TCM word writes followed by back-to-back readback
    for (int j = 0; j < 4; j++) add_write($sformatf("wr_word%0d", j), W_WORD,
                                          TCM_BASE + 32'h100 + 16 * j, rnd_word[j], OK);
    for (int j = 0; j < 4; j++) add_entry($sformatf("rd_word%0d", j), RD, W_WORD,
                                          TCM_BASE + 32'h100 + 16 * j, 32'd0, OK,
                                          rnd_word[j], 1'b0);
    // Lane merging
    merged = merge_lanes(32'h1122_3344, 32'h0000_00AB, W_BYTE, 2'd1);
    merged = merge_lanes(merged, 32'h0000_CDEF, W_HALF, 2'd2);
    add_write("wr_known", W_WORD, K_ADDR, 32'h1122_3344, OK);
    add_write("wr_byte1", W_BYTE, K_ADDR + 1, 32'h0000_00AB, OK);
    add_write("wr_half2", W_HALF, K_ADDR + 2, 32'h0000_CDEF, OK);
    add_entry("rd_merged", RD, W_WORD, K_ADDR, 32'd0, OK, merged, 1'b0);
    add_entry("rd_byte3", RD, W_BYTE, K_ADDR + 3, 32'd0, OK, merged, 1'b0);  // Whole word
    // Errors
    add_entry("rd_half_misal", RD, W_HALF, K_ADDR + 1, 32'd0, ER, 32'd0, 1'b0);
    add_write("wr_word_misal", W_WORD, K_ADDR + 2, 32'hDEAD_BEEF, ER);
    add_entry("rd_unchanged", RD, W_WORD, K_ADDR, 32'd0, OK, merged, 1'b0);
    add_entry("rd_unmapped", RD, W_WORD, 32'h1000_0000, 32'd0, ER, 32'd0, 1'b0);
    add_write("wr_past_timer", W_WORD, TMR_BASE + 32'h20, 32'h5555_AAAA, ER);
    // Timer registers
    add_write("wr_cmp_lo", W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_MTIMECMPLO),
              32'h1234_5678, OK);
    add_write("wr_cmp_hi", W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_MTIMECMPHI),
              32'h9ABC_DEF0, OK);
    add_entry("rd_cmp_lo", RD, W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_MTIMECMPLO),
              32'd0, OK, 32'h1234_5678, 1'b0);
    add_entry("rd_cmp_hi", RD, W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_MTIMECMPHI),
              32'd0, OK, 32'h9ABC_DEF0, 1'b0);
    add_entry("rd_cmp_half", RD, W_HALF, timer_addr(scr1_mem_pkg::SCR1_TIMER_MTIMECMPLO),
              32'd0, ER, 32'd0, 1'b0);
    add_entry("rd_tmr_hole", RD, W_WORD, timer_addr(5'h04), 32'd0, ER, 32'd0, 1'b0);
    add_write("wr_ctrl_half", W_HALF, timer_addr(scr1_mem_pkg::SCR1_TIMER_CTRL), 32'd1, ER);
    add_entry("rd_ctrl_off", RD, W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_CTRL),
              32'd0, OK, 32'd0, 1'b0);
    // Arm the timer
    add_write("wr_cmp_hi0", W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_MTIMECMPHI), 0, OK);
    add_write("wr_cmp_lo20", W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_MTIMECMPLO), 20, OK);
    add_write("wr_mtime_lo", W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_MTIMELO), 0, OK);
    add_write("wr_mtime_hi", W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_MTIMEHI), 0, OK);
    add_write("wr_enable", W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_CTRL), 32'd1, OK);
    run_table();

    wait_irq("irq_rise", 1'b1, 40);

    n_entries = 0;
    add_write("wr_cmp_lo_max", W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_MTIMECMPLO),
              32'hFFFF_FFFF, OK);
    add_write("wr_cmp_hi_max", W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_MTIMECMPHI),
              32'hFFFF_FFFF, OK);
    run_table();

    wait_irq("irq_fall", 1'b0, 4);

    n_entries = 0;
    add_entry("rd_mtime_lo", RD, W_WORD, timer_addr(scr1_mem_pkg::SCR1_TIMER_MTIMELO),
              32'd0, OK, 32'd0, 1'b1);
    run_table();
    n_run++;
    if (t_got[0] < 32'd20) begin
        $display("ERROR mtime_progress: expected at least 20 actual %0d", t_got[0]);
        n_fail++;
    end else begin
        $display("ok    mtime_progress");
    end

    n_fail = n_fail + dut_i.sva_i.assert_fails;
    $display("Checks run: %0d, failed: %0d (assertion failures %0d)",
             n_run, n_fail, dut_i.sva_i.assert_fails);
    if (n_fail == 0) begin
        $display("All tests passed");
    end else begin
        $display("Some tests failed");
    end
    $finish;
end

endmodule : tb_scr1_top_mem

`default_nettype wire
